/* include/sd_init_config.svh */
`ifndef SD_INIT_CONFIG_SVH
`define SD_INIT_CONFIG_SVH

// idle ex_clk cycles between the end of one exchange and the next request
`define SD_CMD_GAP_CYCLES 8

// ex_clk cycles allowed after cmd_done before the response must begin
`define SD_RESP_TIMEOUT 64

// transfer-speed codes handed to the clock divider
// 0x48 selects the 400 kHz identification clock, 0x32 the 25 MHz clock
`define SD_SPEED_IDENT 8'h48
`define SD_SPEED_FAST 8'h32

// R1 card status error bits
// out of range through cc error, csd overwrite, wp erase skip, ake seq error
`define SD_R1_ERR_MASK 32'hFDF9_8008

// R6 status field error bits
// com crc, illegal command, general error, ake seq error
`define SD_R6_ERR_MASK 16'hE008

// OCR voltage window, 2.7 V to 3.6 V
`define SD_OCR_VOLT_LSB 15
`define SD_OCR_VOLT_MSB 23

`endif

/* design/sd_init_pkg.sv */
package sd_init_pkg;

    // identification sequencer states
    typedef enum logic [3:0] {
        S_SLOW_CLK,
        S_CMD0,
        S_CMD55,
        S_ACMD41,
        S_CMD2,
        S_CMD3,
        S_FAST_CLK,
        S_STANDBY,
        S_ERROR,
        S_INACTIVE
    } sd_state_t;

    typedef logic [5:0] cmd_index_t;

    // GO_IDLE_STATE
    localparam cmd_index_t CMD0 = 6'd0;
    // ALL_SEND_CID
    localparam cmd_index_t CMD2 = 6'd2;
    // SEND_RELATIVE_ADDR
    localparam cmd_index_t CMD3 = 6'd3;
    // APP_CMD
    localparam cmd_index_t CMD55 = 6'd55;
    // SD_SEND_OP_COND, only valid after CMD55
    localparam cmd_index_t ACMD41 = 6'd41;

    // command content as the transmitter sends it, index in the upper bits
    typedef struct packed {
        cmd_index_t  index;
        logic [31:0] arg;
    } cmd_frame_t;

    typedef enum logic [2:0] {
        NONE,
        R1,
        R2,
        R3,
        R6
    } resp_kind_t;

    typedef enum logic [1:0] {
        OK,
        BUSY,
        BAD,
        NO_VOLT
    } verdict_t;

endpackage

/* design/sd_resp_checker.sv */
`timescale 1ns/10ps

`include "sd_init_config.svh"

module sd_resp_checker
    import sd_init_pkg::*;
(
    input  logic         ex_clk,
    input  logic         reset,
    input  resp_kind_t   resp_kind,
    input  cmd_index_t   expected_index,
    input  logic         resp_done,
    input  logic         resp_crc_err,
    input  logic [126:0] resp_data,
    input  logic [31:0]  host_ocr,
    output logic         verdict_valid,
    output verdict_t     verdict
);

    cmd_index_t  echo_index;
    logic [31:0] payload;
    logic        index_bad;
    logic        volt_match;
    verdict_t    verdict_d;

    // short responses carry the echoed index above a 32-bit payload
    assign echo_index = resp_data[37:32];
    assign payload    = resp_data[31:0];
    assign index_bad  = (echo_index != expected_index);

    // at least one common voltage step between card and host
    assign volt_match = |(payload[`SD_OCR_VOLT_MSB:`SD_OCR_VOLT_LSB] &
                          host_ocr[`SD_OCR_VOLT_MSB:`SD_OCR_VOLT_LSB]);

    always_comb begin
        verdict_d = OK;
        case (resp_kind)
            R1: begin
                if (resp_crc_err || index_bad || |(payload & `SD_R1_ERR_MASK)) begin
                    verdict_d = BAD;
                end
            end
            R3: begin
                // R3 has no valid crc and a reserved index field
                if (!volt_match) begin
                    verdict_d = NO_VOLT;
                end else if (!payload[31]) begin
                    // power-up not finished yet
                    verdict_d = BUSY;
                end
            end
            R2: begin
                if (resp_crc_err) begin
                    verdict_d = BAD;
                end
            end
            R6: begin
                // low half of the R6 payload is the condensed card status
                if (resp_crc_err || index_bad || |(payload[15:0] & `SD_R6_ERR_MASK)) begin
                    verdict_d = BAD;
                end
            end
            default: begin
                verdict_d = OK;
            end
        endcase
    end

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            verdict_valid <= 1'b0;
            verdict       <= OK;
        end else begin
            verdict_valid <= resp_done;
            if (resp_done) begin
                verdict <= verdict_d;
            end
        end
    end

endmodule

/* design/sd_cmd_issuer.sv */
`timescale 1ns/10ps

`include "sd_init_config.svh"

module sd_cmd_issuer
    import sd_init_pkg::*;
(
    input  logic       ex_clk,
    input  logic       reset,
    input  logic       issue,
    input  cmd_frame_t next_frame,
    input  logic       cmd_busy,
    input  logic       cmd_done,
    input  logic       resp_started,
    input  logic       resp_done,
    input  logic       verdict_valid,
    output logic       cmd_valid,
    output cmd_frame_t cmd_frame,
    output logic       issuer_ready,
    output logic       sent,
    output logic       resp_timeout,
    output cmd_index_t expected_index
);

    localparam int GAP_W = $clog2(`SD_CMD_GAP_CYCLES + 1);
    localparam int TO_W  = $clog2(`SD_RESP_TIMEOUT + 1);

    cmd_frame_t       frame_q;
    logic             pending;
    logic [GAP_W-1:0] gap_cnt;
    logic             watching;
    logic [TO_W-1:0]  to_cnt;
    logic             accept;
    logic             no_resp;
    logic             end_evt;

    assign issuer_ready   = !pending && (gap_cnt == '0);
    assign accept         = issue && issuer_ready;
    assign no_resp        = (frame_q.index == CMD0);
    assign sent           = pending && cmd_done;
    assign resp_timeout   = watching && (to_cnt == TO_W'(`SD_RESP_TIMEOUT));
    // exchange is over at cmd_done for CMD0, otherwise at verdict or timeout
    assign end_evt        = pending && ((sent && no_resp) || verdict_valid || resp_timeout);
    assign cmd_frame      = frame_q;
    assign expected_index = frame_q.index;

    always_ff @(posedge ex_clk) begin
        if (accept) begin
            frame_q <= next_frame;
        end
    end

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            pending   <= 1'b0;
            gap_cnt   <= '0;
            watching  <= 1'b0;
            to_cnt    <= '0;
        end else begin
            // transmitter handshake
            if (accept) begin
                cmd_valid <= 1'b1;
            end else if (cmd_valid && cmd_busy) begin
                cmd_valid <= 1'b0;
            end

            // ready returns SD_CMD_GAP_CYCLES cycles after the ending event
            if (accept) begin
                pending <= 1'b1;
            end else if (end_evt) begin
                pending <= 1'b0;
                gap_cnt <= GAP_W'(`SD_CMD_GAP_CYCLES - 1);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end

            // response watch, stopped for good by any receiver activity
            if (sent && !no_resp) begin
                watching <= 1'b1;
                to_cnt   <= TO_W'(1);
            end else if (resp_started || resp_done || resp_timeout) begin
                watching <= 1'b0;
            end else if (watching) begin
                to_cnt <= to_cnt + 1'b1;
            end
        end
    end

endmodule

/* design/sd_init_seq.sv */
`timescale 1ns/10ps

`include "sd_init_config.svh"

module sd_init_seq
    import sd_init_pkg::*;
(
    input  logic        ex_clk,
    input  logic        reset,
    input  logic        card_detect,
    input  logic [31:0] host_ocr,
    input  logic        clk_ok,
    input  logic        clk_err,
    input  logic        issuer_ready,
    input  logic        sent,
    input  logic        resp_timeout,
    input  logic        verdict_valid,
    input  verdict_t    verdict,
    output logic        clk_req,
    output logic [7:0]  clk_speed,
    output logic        issue,
    output cmd_frame_t  next_frame,
    output resp_kind_t  resp_kind,
    output logic        cid_load,
    output logic        rca_load,
    output sd_state_t   state,
    output logic        init_done,
    output logic        init_error,
    output logic        card_inactive
);

    sd_state_t state_nxt;
    logic      cmd_state;
    logic      verdict_ok;
    logic      err_seen;

    assign verdict_ok = verdict_valid && (verdict == OK);

    // clock divider request, slow clock only once a card is present
    assign clk_req   = (state == S_FAST_CLK) || ((state == S_SLOW_CLK) && card_detect);
    assign clk_speed = (state == S_FAST_CLK) ? `SD_SPEED_FAST : `SD_SPEED_IDENT;

    // issuer_ready stays low from the issue until after the state has moved on,
    // so one pulse per command state
    assign cmd_state = (state == S_CMD0) || (state == S_CMD55) || (state == S_ACMD41) ||
                       (state == S_CMD2) || (state == S_CMD3);
    assign issue     = cmd_state && issuer_ready;

    always_comb begin
        next_frame = '{index: CMD0, arg: 32'h0};
        resp_kind  = NONE;
        case (state)
            S_CMD55: begin
                // rca is still zero during identification
                next_frame = '{index: CMD55, arg: {16'h0000, 16'h0000}};
                resp_kind  = R1;
            end
            S_ACMD41: begin
                next_frame = '{index: ACMD41, arg: {1'b0, host_ocr[30:0]}};
                resp_kind  = R3;
            end
            S_CMD2: begin
                next_frame = '{index: CMD2, arg: 32'h0};
                resp_kind  = R2;
            end
            S_CMD3: begin
                next_frame = '{index: CMD3, arg: 32'h0};
                resp_kind  = R6;
            end
            default: begin
                next_frame = '{index: CMD0, arg: 32'h0};
                resp_kind  = NONE;
            end
        endcase
    end

    // receiver keeps resp_data until the next response starts
    assign cid_load = (state == S_CMD2) && verdict_ok;
    assign rca_load = (state == S_CMD3) && verdict_ok;

    always_comb begin
        state_nxt = state;
        case (state)
            S_SLOW_CLK: begin
                if (card_detect && clk_ok) begin
                    state_nxt = S_CMD0;
                end else if (card_detect && clk_err) begin
                    state_nxt = S_ERROR;
                end
            end
            S_CMD0: begin
                // no response to CMD0
                if (sent) begin
                    state_nxt = S_CMD55;
                end
            end
            S_CMD55, S_CMD2, S_CMD3: begin
                if (resp_timeout) begin
                    state_nxt = S_ERROR;
                end else if (verdict_valid && verdict != OK) begin
                    state_nxt = S_ERROR;
                end else if (verdict_ok) begin
                    case (state)
                        S_CMD55: state_nxt = S_ACMD41;
                        S_CMD2:  state_nxt = S_CMD3;
                        default: state_nxt = S_FAST_CLK;
                    endcase
                end
            end
            S_ACMD41: begin
                if (resp_timeout) begin
                    state_nxt = S_ERROR;
                end else if (verdict_valid) begin
                    case (verdict)
                        OK:      state_nxt = S_CMD2;
                        BUSY:    state_nxt = S_CMD55;
                        NO_VOLT: state_nxt = S_INACTIVE;
                        default: state_nxt = S_ERROR;
                    endcase
                end
            end
            S_FAST_CLK: begin
                if (clk_ok) begin
                    state_nxt = S_STANDBY;
                end else if (clk_err) begin
                    state_nxt = S_ERROR;
                end
            end
            S_ERROR: begin
                state_nxt = S_INACTIVE;
            end
            S_STANDBY: begin
                state_nxt = S_STANDBY;
            end
            default: begin
                state_nxt = S_INACTIVE;
            end
        endcase
    end

    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            state    <= S_SLOW_CLK;
            err_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == S_ERROR) begin
                err_seen <= 1'b1;
            end
        end
    end

    assign init_done     = (state == S_STANDBY);
    // error stays flagged once the card has fallen to inactive
    assign init_error    = (state == S_ERROR) || err_seen;
    assign card_inactive = (state == S_INACTIVE);

endmodule

/* design/sd_card_regs.sv */
`timescale 1ns/10ps

module sd_card_regs (
    input  logic         ex_clk,
    input  logic         reset,
    input  logic         cid_load,
    input  logic         rca_load,
    input  logic [126:0] resp_data,
    output logic [126:0] cid,
    output logic [15:0]  rca,
    output logic [15:0]  card_status
);

    // card identification from the R2 response, crc bits already stripped
    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            cid <= '0;
        end else if (cid_load) begin
            cid <= resp_data;
        end
    end

    // R6 payload is new rca above the condensed status
    always_ff @(posedge ex_clk or posedge reset) begin
        if (reset) begin
            rca         <= 16'h0000;
            card_status <= 16'h0000;
        end else if (rca_load) begin
            rca         <= resp_data[31:16];
            card_status <= resp_data[15:0];
        end
    end

endmodule

/* design/sd_init_top.sv */
`timescale 1ns/10ps

module sd_init_top
    import sd_init_pkg::*;
(
    input  logic         ex_clk,
    input  logic         reset,
    input  logic         card_detect,
    input  logic [31:0]  host_ocr,
    // command transmitter
    output logic         cmd_valid,
    output cmd_frame_t   cmd_frame,
    input  logic         cmd_busy,
    input  logic         cmd_done,
    // response receiver
    output resp_kind_t   resp_kind,
    input  logic         resp_started,
    input  logic         resp_done,
    input  logic         resp_crc_err,
    input  logic [126:0] resp_data,
    // clock divider
    output logic         clk_req,
    output logic [7:0]   clk_speed,
    input  logic         clk_ok,
    input  logic         clk_err,
    // status
    output sd_state_t    state,
    output logic [126:0] cid,
    output logic [15:0]  rca,
    output logic [15:0]  card_status,
    output logic         init_done,
    output logic         init_error,
    output logic         card_inactive
);

    logic       issue;
    cmd_frame_t next_frame;
    logic       issuer_ready;
    logic       sent;
    logic       resp_timeout;
    cmd_index_t expected_index;
    logic       verdict_valid;
    verdict_t   verdict;
    logic       cid_load;
    logic       rca_load;

    sd_resp_checker u_checker (
        .ex_clk         (ex_clk),
        .reset          (reset),
        .resp_kind      (resp_kind),
        .expected_index (expected_index),
        .resp_done      (resp_done),
        .resp_crc_err   (resp_crc_err),
        .resp_data      (resp_data),
        .host_ocr       (host_ocr),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict)
    );

    sd_init_seq u_seq (
        .ex_clk        (ex_clk),
        .reset         (reset),
        .card_detect   (card_detect),
        .host_ocr      (host_ocr),
        .clk_ok        (clk_ok),
        .clk_err       (clk_err),
        .issuer_ready  (issuer_ready),
        .sent          (sent),
        .resp_timeout  (resp_timeout),
        .verdict_valid (verdict_valid),
        .verdict       (verdict),
        .clk_req       (clk_req),
        .clk_speed     (clk_speed),
        .issue         (issue),
        .next_frame    (next_frame),
        .resp_kind     (resp_kind),
        .cid_load      (cid_load),
        .rca_load      (rca_load),
        .state         (state),
        .init_done     (init_done),
        .init_error    (init_error),
        .card_inactive (card_inactive)
    );

    sd_cmd_issuer u_issuer (
        .ex_clk         (ex_clk),
        .reset          (reset),
        .issue          (issue),
        .next_frame     (next_frame),
        .cmd_busy       (cmd_busy),
        .cmd_done       (cmd_done),
        .resp_started   (resp_started),
        .resp_done      (resp_done),
        .verdict_valid  (verdict_valid),
        .cmd_valid      (cmd_valid),
        .cmd_frame      (cmd_frame),
        .issuer_ready   (issuer_ready),
        .sent           (sent),
        .resp_timeout   (resp_timeout),
        .expected_index (expected_index)
    );

    sd_card_regs u_regs (
        .ex_clk      (ex_clk),
        .reset       (reset),
        .cid_load    (cid_load),
        .rca_load    (rca_load),
        .resp_data   (resp_data),
        .cid         (cid),
        .rca         (rca),
        .card_status (card_status)
    );

endmodule

/* verif/sd_card_model.sv */
`timescale 1ns/10ps

module sd_card_model
    import sd_init_pkg::*;
#(
    parameter int          MAX_STALL   = 3,
    parameter int          MAX_BUSY    = 3,
    parameter logic [15:0] CARD_STATUS = 16'h0500
) (
    input  logic         ex_clk,
    input  logic         reset,
    input  logic         crc_on_cid,
    input  logic         silent_app_cmd,
    input  logic         bad_voltage,
    input  logic         cmd_valid,
    input  cmd_frame_t   cmd_frame,
    output logic         cmd_busy,
    output logic         cmd_done,
    output logic         resp_started,
    output logic         resp_done,
    output logic         resp_crc_err,
    output logic [126:0] resp_data,
    input  logic         clk_req,
    output logic         clk_ok,
    output logic         clk_err,
    output logic [2:0]   busy_count,
    output logic [126:0] card_cid,
    output logic [15:0]  card_rca
);

    int busy_left;

    // transmitter stall, send time, then the card answer
    task automatic serve_command(input cmd_frame_t frame);
        logic [31:0] ocr;
        repeat ($urandom_range(MAX_STALL, 0)) @(posedge ex_clk);
        #1 cmd_busy = 1'b1;
        repeat (2) @(posedge ex_clk);
        #1;
        cmd_busy = 1'b0;
        cmd_done = 1'b1;
        @(posedge ex_clk);
        #1 cmd_done = 1'b0;
        // CMD0 has no response, a silent card ignores CMD55
        if (frame.index == CMD0 || (silent_app_cmd && frame.index == CMD55)) begin
            return;
        end
        repeat ($urandom_range(20, 1)) @(posedge ex_clk);
        #1 resp_started = 1'b1;
        @(posedge ex_clk);
        #1 resp_started = 1'b0;
        repeat (3) @(posedge ex_clk);
        #1;
        resp_crc_err = 1'b0;
        case (frame.index)
            CMD55: begin
                // ready for data and app_cmd set
                resp_data = {89'h0, CMD55, 32'h0000_0120};
            end
            ACMD41: begin
                ocr = {(busy_left == 0), 7'h00, bad_voltage ? 24'h00_0000 : 24'hFF_8000};
                if (busy_left != 0) begin
                    busy_left = busy_left - 1;
                end
                resp_data = {89'h0, 6'h3F, ocr};
            end
            CMD2: begin
                resp_data    = card_cid;
                resp_crc_err = crc_on_cid;
            end
            default: begin
                resp_data = {89'h0, CMD3, card_rca, CARD_STATUS};
            end
        endcase
        resp_done = 1'b1;
        @(posedge ex_clk);
        #1;
        resp_done    = 1'b0;
        resp_crc_err = 1'b0;
    endtask

    initial begin
        cmd_busy     = 1'b0;
        cmd_done     = 1'b0;
        resp_started = 1'b0;
        resp_done    = 1'b0;
        resp_crc_err = 1'b0;
        resp_data    = '0;
        busy_count   = '0;
        card_cid     = '0;
        card_rca     = '0;
        busy_left    = 0;
        forever begin
            @(posedge ex_clk);
            if (!reset && cmd_valid) begin
                serve_command(cmd_frame);
            end
        end
    end

    // a new card for every test
    always @(negedge reset) begin
        busy_count = 3'($urandom_range(MAX_BUSY, 0));
        card_cid   = 127'({$urandom, $urandom, $urandom, $urandom});
        card_rca   = 16'($urandom);
        busy_left  = busy_count;
    end

    // clock divider, settles a few cycles after each request
    initial begin
        clk_ok  = 1'b0;
        clk_err = 1'b0;
        forever begin
            @(posedge ex_clk);
            if (!reset && clk_req) begin
                repeat ($urandom_range(4, 1)) @(posedge ex_clk);
                #1 clk_ok = 1'b1;
                @(posedge ex_clk);
                #1 clk_ok = 1'b0;
            end
        end
    end

endmodule

/* verif/sd_init_tb.sv */
`timescale 1ns/10ps

`include "sd_init_config.svh"

module sd_init_tb
    import sd_init_pkg::*;
();

    localparam int MAX_STALL    = 3;
    localparam int MAX_BUSY     = 3;
    localparam int RESET_CYCLES = 10;
    localparam int TAIL_CYCLES  = 20;
    localparam int NUM_TESTS    = 5;
    // one exchange at its slowest, silent card included
    localparam int CMD_WORST    = `SD_CMD_GAP_CYCLES + MAX_STALL + `SD_RESP_TIMEOUT + 16;
    // every command of the longest sequence plus reset and both clock requests
    localparam int TEST_WORST   = RESET_CYCLES + TAIL_CYCLES + 32 +
                                  (3 + 2 * (MAX_BUSY + 1)) * CMD_WORST;
    localparam int CYCLE_LIMIT  = NUM_TESTS * TEST_WORST;
    localparam logic [31:0] HOST_OCR = 32'hC0FF_8000;
    // condensed status the card returns with CMD3
    localparam logic [15:0] CARD_STATUS = 16'h0500;

    logic         ex_clk;
    logic         reset;
    logic         card_detect;
    logic [31:0]  host_ocr;
    logic         cmd_valid;
    cmd_frame_t   cmd_frame;
    logic         cmd_busy;
    logic         cmd_done;
    resp_kind_t   resp_kind;
    logic         resp_started;
    logic         resp_done;
    logic         resp_crc_err;
    logic [126:0] resp_data;
    logic         clk_req;
    logic [7:0]   clk_speed;
    logic         clk_ok;
    logic         clk_err;
    sd_state_t    state;
    logic [126:0] cid;
    logic [15:0]  rca;
    logic [15:0]  card_status;
    logic         init_done;
    logic         init_error;
    logic         card_inactive;
    logic         crc_on_cid;
    logic         silent_app_cmd;
    logic         bad_voltage;
    logic [2:0]   busy_count;
    logic [126:0] card_cid;
    logic [15:0]  card_rca;

    int          cycle = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned seed;
    cmd_index_t  seen_cmds[$];
    cmd_index_t  exp_cmds[$];
    logic [7:0]  speeds[$];
    logic        prev_valid;
    logic        prev_busy;
    cmd_frame_t  prev_frame;
    cmd_index_t  cur_index = '1;
    logic        end_pending;
    int          last_end;
    int          done_cycle;
    int          err_cycle;
    int          inact_cycle;

    sd_init_top uut (
        .ex_clk(ex_clk), .reset(reset), .card_detect(card_detect), .host_ocr(host_ocr),
        .cmd_valid(cmd_valid), .cmd_frame(cmd_frame), .cmd_busy(cmd_busy),
        .cmd_done(cmd_done), .resp_kind(resp_kind), .resp_started(resp_started),
        .resp_done(resp_done), .resp_crc_err(resp_crc_err), .resp_data(resp_data),
        .clk_req(clk_req), .clk_speed(clk_speed), .clk_ok(clk_ok), .clk_err(clk_err),
        .state(state), .cid(cid), .rca(rca), .card_status(card_status),
        .init_done(init_done), .init_error(init_error), .card_inactive(card_inactive)
    );

    sd_card_model #(
        .MAX_STALL(MAX_STALL), .MAX_BUSY(MAX_BUSY), .CARD_STATUS(CARD_STATUS)
    ) card (
        .ex_clk(ex_clk), .reset(reset), .crc_on_cid(crc_on_cid),
        .silent_app_cmd(silent_app_cmd), .bad_voltage(bad_voltage),
        .cmd_valid(cmd_valid), .cmd_frame(cmd_frame), .cmd_busy(cmd_busy),
        .cmd_done(cmd_done), .resp_started(resp_started), .resp_done(resp_done),
        .resp_crc_err(resp_crc_err), .resp_data(resp_data), .clk_req(clk_req),
        .clk_ok(clk_ok), .clk_err(clk_err), .busy_count(busy_count),
        .card_cid(card_cid), .card_rca(card_rca)
    );

    initial begin
        ex_clk = 1'b0;
        forever #4 ex_clk = ~ex_clk;
    end

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            error_count = error_count + 1;
        end
    endtask

    // response the receiver has to expect for each command
    function automatic resp_kind_t kind_for_command(input cmd_index_t index);
        case (index)
            CMD0:    return NONE;
            CMD55:   return R1;
            ACMD41:  return R3;
            CMD2:    return R2;
            CMD3:    return R6;
            default: return NONE;
        endcase
    endfunction

    // bus observer, values sampled as the DUT sees them at the edge
    task automatic watch_bus();
        if (cmd_valid && !prev_valid) begin
            seen_cmds.push_back(cmd_frame.index);
            cur_index = cmd_frame.index;
            check_value("resp_kind", resp_kind, kind_for_command(cmd_frame.index));
            if (end_pending) begin
                check_value("gap to cmd_valid", cycle - last_end, `SD_CMD_GAP_CYCLES + 1);
                end_pending = 1'b0;
            end
            if (cmd_frame.index == ACMD41) begin
                check_value("ACMD41 argument", cmd_frame.arg, host_ocr & 32'h7FFF_FFFF);
            end
        end
        // not yet accepted by the transmitter
        if (prev_valid && !prev_busy) begin
            check_value("cmd_valid held", cmd_valid, 1'b1);
            check_value("cmd_frame stable", cmd_frame, prev_frame);
        end
        if (cmd_done) begin
            done_cycle = cycle;
            if (cur_index == CMD0) begin
                last_end    = cycle;
                end_pending = 1'b1;
            end
        end
        if (resp_done) begin
            // verdict one cycle after the response
            last_end    = cycle + 1;
            end_pending = 1'b1;
        end
        if (clk_req && clk_ok) begin
            speeds.push_back(clk_speed);
        end
        if (state == S_ERROR && err_cycle < 0) begin
            err_cycle = cycle;
        end
        if (card_inactive && inact_cycle < 0) begin
            inact_cycle = cycle;
        end
        prev_valid = cmd_valid;
        prev_busy  = cmd_busy;
        prev_frame = cmd_frame;
    endtask

    always @(posedge ex_clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: %0d cycles passed before all tests finished", cycle);
            $display("Simulation failed");
            $finish;
        end else if (reset) begin
            prev_valid  = 1'b0;
            prev_busy   = 1'b0;
            end_pending = 1'b0;
            err_cycle   = -1;
            inact_cycle = -1;
        end else begin
            watch_bus();
        end
    end

    task automatic apply_reset(input bit crc, input bit silent, input bit volt);
        @(posedge ex_clk);
        #1;
        reset          = 1'b1;
        card_detect    = 1'b0;
        crc_on_cid     = crc;
        silent_app_cmd = silent;
        bad_voltage    = volt;
        seen_cmds      = {};
        speeds         = {};
        repeat (RESET_CYCLES) @(posedge ex_clk);
        #1 reset = 1'b0;
        // card inserted a little after reset
        repeat (3) @(posedge ex_clk);
        #1 card_detect = 1'b1;
    endtask

    task automatic build_expected(input bit crc, input bit silent, input bit volt);
        exp_cmds = {};
        exp_cmds.push_back(CMD0);
        if (volt) begin
            exp_cmds.push_back(CMD55);
            exp_cmds.push_back(ACMD41);
        end else if (silent) begin
            exp_cmds.push_back(CMD55);
        end else begin
            repeat (busy_count + 1) begin
                exp_cmds.push_back(CMD55);
                exp_cmds.push_back(ACMD41);
            end
            exp_cmds.push_back(CMD2);
            if (!crc) begin
                exp_cmds.push_back(CMD3);
            end
        end
    endtask

    task automatic compare_commands();
        check_value("command count", seen_cmds.size(), exp_cmds.size());
        for (int i = 0; i < seen_cmds.size() && i < exp_cmds.size(); i++) begin
            check_value($sformatf("command %0d index", i), seen_cmds[i], exp_cmds[i]);
        end
    endtask

    task automatic run_test(input string name, input bit crc, input bit silent, input bit volt);
        int errors_before;
        errors_before = error_count;
        apply_reset(crc, silent, volt);
        while (!(init_done || card_inactive)) begin
            @(posedge ex_clk);
        end
        // later commands would show up here
        repeat (TAIL_CYCLES) @(posedge ex_clk);
        build_expected(crc, silent, volt);
        compare_commands();
        if (!crc && !silent && !volt) begin
            check_value("init_done", init_done, 1'b1);
            check_value("init_error", init_error, 1'b0);
            check_value("cid", cid, card_cid);
            check_value("rca", rca, card_rca);
            check_value("card_status", card_status, CARD_STATUS);
            check_value("clock requests", speeds.size(), 2);
            if (speeds.size() == 2) begin
                check_value("first clk_speed", speeds[0], `SD_SPEED_IDENT);
                check_value("second clk_speed", speeds[1], `SD_SPEED_FAST);
            end
        end else begin
            check_value("init_done", init_done, 1'b0);
            check_value("card_inactive", card_inactive, 1'b1);
            check_value("init_error", init_error, !volt);
            if (!volt) begin
                check_value("error before inactive",
                            err_cycle >= 0 && inact_cycle > err_cycle, 1'b1);
            end
            if (silent) begin
                check_value("cmd_done to error state", err_cycle - done_cycle,
                            `SD_RESP_TIMEOUT + 1);
            end
        end
        tests_run = tests_run + 1;
        if (error_count == errors_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial begin
        seed = 32'hc0735efd;
        void'($urandom(seed));
        reset          = 1'b1;
        card_detect    = 1'b0;
        host_ocr       = HOST_OCR;
        crc_on_cid     = 1'b0;
        silent_app_cmd = 1'b0;
        bad_voltage    = 1'b0;
        run_test("normal init", 1'b0, 1'b0, 1'b0);
        run_test("normal init, second card", 1'b0, 1'b0, 1'b0);
        run_test("crc error on CMD2", 1'b1, 1'b0, 1'b0);
        run_test("silent card after CMD55", 1'b0, 1'b1, 1'b0);
        run_test("voltage mismatch", 1'b0, 1'b0, 1'b1);
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sd_init_top.f */
+incdir+include
design/sd_init_pkg.sv
design/sd_resp_checker.sv
design/sd_cmd_issuer.sv
design/sd_init_seq.sv
design/sd_card_regs.sv
design/sd_init_top.sv
verif/sd_card_model.sv
verif/sd_init_tb.sv

/* Bender.yml */
package:
  name: sd_init_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/sd_init_pkg.sv
      - design/sd_resp_checker.sv
      - design/sd_cmd_issuer.sv
      - design/sd_init_seq.sv
      - design/sd_card_regs.sv
      - design/sd_init_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/sd_card_model.sv
      - verif/sd_init_tb.sv
